/* src.f */
src/sdram_pkg.sv
src/sdram_refresh_timer.sv
src/sdram_bank_tracker.sv
src/sdram_sequencer.sv
src/sdram_cmd_issue.sv
src/sdram_ctrl_top.sv
dv/sdram_model.sv
dv/tb_sdram_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SDRAM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_sdram_ctrl \
    -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "simulation build or run failed" >> sim.log
cat sim.log
if grep -q "TEST FAILED" sim.log || ! grep -q "TEST OK" sim.log; then
    exit 1
fi
exit 0

/* dv/tb_sdram_ctrl.sv */
// SDRAM controller testbench
`timescale 1ns/1ns

module tb_sdram_ctrl;
    import sdram_pkg::*;

    localparam int READ_LATENCY = 2;
    localparam int TIMEOUT      = 2000;

    logic clk_i = 1'b0;
    logic rst_i = 1'b1;
    logic [3:0] req_wr_i = '0;
    logic req_rd_i = 1'b0;
    logic [31:0] req_addr_i = '0;
    logic [31:0] req_wdata_i = '0;
    logic req_accept_o, req_ack_o, sdram_clk, cke, cs, ras, cas, we, dq_oe;
    logic [31:0] req_rdata_o, dq_out, dq_in;
    logic [1:0] ba;
    logic [12:0] addr_bus;
    logic [3:0] dqm;
    logic [31:0] rng = 32'h2a3e;
    logic [31:0] sb [int];
    // Pin monitor state
    logic [3:0] last_cmd = CMD_NOP;
    logic last_ap = 1'b0;
    logic mode_loaded = 1'b0;
    logic [16:0] init_log [$];
    int refresh_count = 0;
    int miss_pch_count = 0;
    logic [12:0] last_act_row = '0;

    always #4 clk_i = ~clk_i;

    sdram_ctrl_top #(.READ_LATENCY(READ_LATENCY), .START_CYCLES(200), .REFRESH_CYCLES(300)) uut (
        .clk_i(clk_i), .rst_i(rst_i), .req_wr_i(req_wr_i), .req_rd_i(req_rd_i),
        .req_addr_i(req_addr_i), .req_wdata_i(req_wdata_i), .req_accept_o(req_accept_o),
        .req_ack_o(req_ack_o), .req_rdata_o(req_rdata_o), .sdram_clk_o(sdram_clk),
        .sdram_cke_o(cke), .sdram_cs_o(cs), .sdram_ras_o(ras), .sdram_cas_o(cas),
        .sdram_we_o(we), .sdram_ba_o(ba), .sdram_addr_o(addr_bus), .sdram_dqm_o(dqm),
        .sdram_dq_o(dq_out), .sdram_dq_oe_o(dq_oe), .sdram_dq_i(dq_in));

    sdram_model u_model (
        .sdram_clk_i(sdram_clk), .cke_i(cke), .cs_i(cs), .ras_i(ras), .cas_i(cas),
        .we_i(we), .ba_i(ba), .addr_i(addr_bus), .dqm_i(dqm), .dq_i(dq_out),
        .dq_oe_i(dq_oe), .dq_o(dq_in));

    task automatic stop_with(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERR %0t %s got %h expected %h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    // Byte address from row, bank and column
    function automatic logic [31:0] make_addr(input int row, input int bank, input int col);
        return {6'b0, 13'(row), 2'(bank), 9'(col), 2'b00};
    endfunction

    // ----------------------------------------------------------------------
    // Pin monitor sampled at the falling edge where pins are stable
    // ----------------------------------------------------------------------
    always @(negedge clk_i)
    begin
        if (!rst_i)
        begin
            if (!cke && {cs, ras, cas, we} != CMD_NOP)
                stop_with("command issued before cke was raised");
            if (req_accept_o && !mode_loaded)
                stop_with("request accepted before mode register load");
            if ({cs, ras, cas, we} != CMD_NOP)
            begin
                if (!mode_loaded)
                    init_log.push_back({{cs, ras, cas, we}, addr_bus});
                if ({cs, ras, cas, we} == CMD_LOAD_MODE)
                    mode_loaded = 1'b1;
                else if ({cs, ras, cas, we} == CMD_REFRESH && mode_loaded)
                begin
                    refresh_count++;
                    if (last_cmd != CMD_PRECHARGE || !last_ap)
                        stop_with("refresh without a preceding precharge-all");
                end
                else if ({cs, ras, cas, we} == CMD_PRECHARGE && !addr_bus[AP_BIT])
                    miss_pch_count++;
                else if ({cs, ras, cas, we} == CMD_ACTIVE)
                    last_act_row = addr_bus;
                last_cmd = {cs, ras, cas, we};
                last_ap  = addr_bus[AP_BIT];
            end
        end
    end

    // One access timed from accept to ack
    task automatic access(input logic rd, input logic [3:0] mask, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        @(posedge clk_i);
        req_rd_i    <= rd;
        req_wr_i    <= rd ? 4'b0 : mask;
        req_addr_i  <= addr;
        req_wdata_i <= wdata;
        n = 0;
        do
        begin
            @(negedge clk_i);
            n++;
            if (n > TIMEOUT)
                stop_with("timeout waiting for request accept");
        end while (!req_accept_o);
        @(posedge clk_i);
        req_rd_i <= 1'b0;
        req_wr_i <= 4'b0;
        n = 0;
        do
        begin
            @(negedge clk_i);
            n++;
            if (!rd && n == 1)
            begin
                check_equal("write command", 32'({cs, ras, cas, we}), 32'(CMD_WRITE));
                check_equal("write dqm", {28'b0, dqm}, {28'b0, ~mask});
            end
            if (n > TIMEOUT)
                stop_with("timeout waiting for request ack");
        end while (!req_ack_o);
        check_equal("ack latency", n, rd ? READ_LATENCY + 2 : 1);
        rdata = req_rdata_o;
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [3:0] mask,
                              input logic [31:0] data);
        logic [31:0] unused;
        logic [31:0] word;
        word = sb.exists(int'(addr >> 2)) ? sb[int'(addr >> 2)] : 32'h0;
        for (int b = 0; b < 4; b++)
            if (mask[b])
                word[8*b +: 8] = data[8*b +: 8];
        sb[int'(addr >> 2)] = word;
        access(1'b0, mask, addr, data, unused);
    endtask

    task automatic read_check(input logic [31:0] addr);
        logic [31:0] got;
        access(1'b1, 4'b0, addr, 32'h0, got);
        check_equal("read data", got, sb.exists(int'(addr >> 2)) ? sb[int'(addr >> 2)] : 32'h0);
    endtask

    task automatic power_up_order();
        logic [31:0] addr;
        addr = make_addr(1, 0, 3);
        // Write held from reset release so an early accept trips the monitor
        write_word(addr, 4'hf, xorshift());
        check_equal("init command count", init_log.size(), 4);
        check_equal("init precharge-all", 32'(init_log[0]), 32'({CMD_PRECHARGE, 13'h0400}));
        check_equal("init refresh 1", 32'(init_log[1][16:13]), 32'(CMD_REFRESH));
        check_equal("init refresh 2", 32'(init_log[2][16:13]), 32'(CMD_REFRESH));
        check_equal("init load mode", 32'(init_log[3]), 32'({CMD_LOAD_MODE, 13'(MODE_CAS2)}));
        read_check(addr);
    endtask

    task automatic same_row_write_read();
        for (int i = 0; i < 8; i++)
            write_word(make_addr(3, 1, i), 4'hf, xorshift());
        for (int i = 0; i < 8; i++)
            read_check(make_addr(3, 1, i));
    endtask

    task automatic byte_mask_writes();
        for (int m = 1; m < 15; m++)
        begin
            write_word(make_addr(3, 2, m), 4'hf, xorshift());
            write_word(make_addr(3, 2, m), 4'(m), xorshift());
            read_check(make_addr(3, 2, m));
        end
    endtask

    task automatic row_miss_paths();
        int pch;
        int refs;
        write_word(make_addr(5, 0, 7), 4'hf, xorshift());
        pch  = miss_pch_count;
        refs = refresh_count;
        write_word(make_addr(9, 0, 7), 4'hf, xorshift());
        // A refresh in between already closed the bank
        if (refresh_count == refs)
            check_equal("miss precharge count", miss_pch_count, pch + 1);
        check_equal("new active row", 32'(last_act_row), 32'd9);
        pch = miss_pch_count;
        write_word(make_addr(4, 3, 2), 4'hf, xorshift());
        read_check(make_addr(4, 3, 2));
        check_equal("other bank precharge", miss_pch_count, pch);
        read_check(make_addr(5, 0, 7));
        read_check(make_addr(9, 0, 7));
    endtask

    task automatic refresh_under_traffic();
        logic [31:0] r;
        logic [31:0] a;
        int refs;
        refs = refresh_count;
        for (int i = 0; i < 300; i++)
        begin
            r = xorshift();
            a = make_addr(int'(r[1:0]), int'(r[3:2]), int'(r[6:4]));
            if (r[7] && sb.exists(int'(a >> 2)))
                read_check(a);
            else
                write_word(a, r[11:8] | 4'b0001, xorshift());
        end
        if (refresh_count < refs + 2)
            stop_with("periodic refresh did not recur during traffic");
    endtask

    initial
    begin
        repeat (16) @(posedge clk_i);
        rst_i <= 1'b0;
        power_up_order();
        same_row_write_read();
        byte_mask_writes();
        row_miss_paths();
        refresh_under_traffic();
        $display("TEST OK");
        $finish;
    end

endmodule

/* dv/sdram_model.sv */
// Behavioral SDRAM device
`timescale 1ns/1ns

module sdram_model
#(
    parameter int COL_W = 9
)
(
    input  logic                             sdram_clk_i,
    input  logic                             cke_i,
    input  logic                             cs_i,
    input  logic                             ras_i,
    input  logic                             cas_i,
    input  logic                             we_i,
    input  logic [sdram_pkg::BANK_W-1:0]     ba_i,
    input  logic [sdram_pkg::ADDR_BUS_W-1:0] addr_i,
    input  logic [sdram_pkg::MASK_W-1:0]     dqm_i,
    input  logic [sdram_pkg::DATA_W-1:0]     dq_i,
    input  logic                             dq_oe_i,
    output logic [sdram_pkg::DATA_W-1:0]     dq_o
);
    import sdram_pkg::*;

    logic [DATA_W-1:0]     mem [int];
    logic [ADDR_BUS_W-1:0] open_row [4];
    logic [3:0]            cmd;
    sdram_addr_u           bus;
    int                    key;

    assign cmd = {cs_i, ras_i, cas_i, we_i};
    assign bus = addr_i;
    // Word key from bank, open row and column
    assign key = int'({ba_i, open_row[ba_i], bus.col.column[COL_W-1:0]});

    // Read word on DQ while READ is on the pins
    always_comb
    begin
        if (cmd == CMD_READ && mem.exists(key))
            dq_o = mem[key];
        else
            dq_o = '0;
    end

    always @(posedge sdram_clk_i)
    begin
        if (cke_i && cmd == CMD_ACTIVE)
            open_row[ba_i] <= addr_i;
        if (cke_i && cmd == CMD_WRITE && dq_oe_i)
        begin
            if (!mem.exists(key))
                mem[key] = '0;
            // DQM high leaves the byte alone
            for (int b = 0; b < MASK_W; b++)
                if (!dqm_i[b])
                    mem[key][8*b +: 8] = dq_i[8*b +: 8];
        end
    end

endmodule

/* src/sdram_ctrl_top.sv */
// SDRAM controller top level
`timescale 1ns/1ns

module sdram_ctrl_top
#(
    parameter int COL_W          = 9,
    parameter int ROW_W          = 13,
    parameter int READ_LATENCY   = 2,
    parameter int START_CYCLES   = 5100,
    parameter int REFRESH_CYCLES = 780
)
(
    input  logic                             clk_i,
    input  logic                             rst_i,
    // Request port
    input  logic [sdram_pkg::MASK_W-1:0]     req_wr_i,
    input  logic                             req_rd_i,
    input  logic [31:0]                      req_addr_i,
    input  logic [sdram_pkg::DATA_W-1:0]     req_wdata_i,
    output logic                             req_accept_o,
    output logic                             req_ack_o,
    output logic [sdram_pkg::DATA_W-1:0]     req_rdata_o,
    // SDRAM device pins
    output logic                             sdram_clk_o,
    output logic                             sdram_cke_o,
    output logic                             sdram_cs_o,
    output logic                             sdram_ras_o,
    output logic                             sdram_cas_o,
    output logic                             sdram_we_o,
    output logic [sdram_pkg::BANK_W-1:0]     sdram_ba_o,
    output logic [sdram_pkg::ADDR_BUS_W-1:0] sdram_addr_o,
    output logic [sdram_pkg::MASK_W-1:0]     sdram_dqm_o,
    output logic [sdram_pkg::DATA_W-1:0]     sdram_dq_o,
    output logic                             sdram_dq_oe_o,
    input  logic [sdram_pkg::DATA_W-1:0]     sdram_dq_i
);
    import sdram_pkg::*;

    seq_state_t         state;
    logic               req_any;
    logic [BANK_W-1:0]  req_bank;
    logic [ROW_W-1:0]   req_row;
    logic               refresh_pending;
    logic               refresh_done;
    logic [TIMER_W-1:0] init_count;
    logic               bank_open;
    logic               row_hit;
    logic               open_row;
    logic               close_bank;
    logic               close_all;

    // Any byte enable or a read makes a request
    assign req_any  = (|req_wr_i) | req_rd_i;
    assign req_bank = req_addr_i[COL_W+3:COL_W+2];
    assign req_row  = req_addr_i[ROW_W+COL_W+3:COL_W+4];

    sdram_refresh_timer #(
        .START_CYCLES   (START_CYCLES),
        .REFRESH_CYCLES (REFRESH_CYCLES)
    ) u_timer (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .refresh_done_i    (refresh_done),
        .refresh_pending_o (refresh_pending),
        .init_count_o      (init_count)
    );

    sdram_bank_tracker #(
        .ROW_W (ROW_W)
    ) u_tracker (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .bank_i       (req_bank),
        .row_i        (req_row),
        .open_row_i   (open_row),
        .close_bank_i (close_bank),
        .close_all_i  (close_all),
        .bank_open_o  (bank_open),
        .row_hit_o    (row_hit)
    );

    sdram_sequencer #(
        .READ_LATENCY (READ_LATENCY)
    ) u_seq (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .req_rd_i          (req_rd_i),
        .req_any_i         (req_any),
        .refresh_pending_i (refresh_pending),
        .bank_open_i       (bank_open),
        .row_hit_i         (row_hit),
        .state_o           (state),
        .refresh_done_o    (refresh_done),
        .open_row_o        (open_row),
        .close_bank_o      (close_bank),
        .close_all_o       (close_all)
    );

    sdram_cmd_issue #(
        .COL_W        (COL_W),
        .ROW_W        (ROW_W),
        .READ_LATENCY (READ_LATENCY)
    ) u_issue (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .state_i      (state),
        .close_all_i  (close_all),
        .init_count_i (init_count),
        .addr_i       (req_addr_i),
        .wr_i         (req_wr_i),
        .wdata_i      (req_wdata_i),
        .dq_i         (sdram_dq_i),
        .cke_o        (sdram_cke_o),
        .cs_o         (sdram_cs_o),
        .ras_o        (sdram_ras_o),
        .cas_o        (sdram_cas_o),
        .we_o         (sdram_we_o),
        .ba_o         (sdram_ba_o),
        .addr_o       (sdram_addr_o),
        .dqm_o        (sdram_dqm_o),
        .dq_o         (sdram_dq_o),
        .dq_oe_o      (sdram_dq_oe_o),
        .ack_o        (req_ack_o),
        .rdata_o      (req_rdata_o)
    );

    // Request taken in the cycle its column command is chosen
    assign req_accept_o = (state == ST_READ) || (state == ST_WRITE);

    // Device clocks on the falling edge, mid-way through each pin cycle
    assign sdram_clk_o = ~clk_i;

endmodule

/* src/sdram_cmd_issue.sv */
// SDRAM pin registers and read return
`timescale 1ns/1ns

module sdram_cmd_issue
#(
    parameter int COL_W        = 9,
    parameter int ROW_W        = 13,
    parameter int READ_LATENCY = 2
)
(
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  sdram_pkg::seq_state_t             state_i,
    input  logic                              close_all_i,
    input  logic [sdram_pkg::TIMER_W-1:0]     init_count_i,
    input  logic [31:0]                       addr_i,
    input  logic [sdram_pkg::MASK_W-1:0]      wr_i,
    input  logic [sdram_pkg::DATA_W-1:0]      wdata_i,
    input  logic [sdram_pkg::DATA_W-1:0]      dq_i,
    output logic                              cke_o,
    output logic                              cs_o,
    output logic                              ras_o,
    output logic                              cas_o,
    output logic                              we_o,
    output logic [sdram_pkg::BANK_W-1:0]      ba_o,
    output logic [sdram_pkg::ADDR_BUS_W-1:0]  addr_o,
    output logic [sdram_pkg::MASK_W-1:0]      dqm_o,
    output logic [sdram_pkg::DATA_W-1:0]      dq_o,
    output logic                              dq_oe_o,
    output logic                              ack_o,
    output logic [sdram_pkg::DATA_W-1:0]      rdata_o
);
    import sdram_pkg::*;

    sdram_cmd_t          cmd_q;
    sdram_addr_u         addr_q;
    sdram_addr_u         col_word;
    logic [BANK_W-1:0]   bank_q;
    logic [BANK_W-1:0]   bank;
    logic [ROW_W-1:0]    row;
    logic [MASK_W-1:0]   dqm_q;
    logic                cke_q;
    logic                dq_oe_q;
    logic                ack_q;
    logic [READ_LATENCY:0] rd_q;
    logic [DATA_W-1:0]   data_q;
    logic [DATA_W-1:0]   sample0_q;
    logic [DATA_W-1:0]   sample1_q;
    logic [DATA_W-1:0]   rdata_q;

    // Byte address split
    assign bank = addr_i[COL_W+3:COL_W+2];
    assign row  = addr_i[ROW_W+COL_W+3:COL_W+4];

    // Column word with auto-precharge off so the row stays open
    always_comb
    begin
        col_word            = '0;
        col_word.col.column = AP_BIT'(addr_i[COL_W+1:2]);
    end

    // ----------------------------------------------------------------------
    // Command, address and mask pins
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            cmd_q   <= CMD_NOP;
            addr_q  <= '0;
            bank_q  <= '0;
            dqm_q   <= '0;
            cke_q   <= 1'b0;
            dq_oe_q <= 1'b0;
        end
        else
        begin
            // NOP unless the state issues something
            cmd_q   <= CMD_NOP;
            addr_q  <= '0;
            bank_q  <= '0;
            dq_oe_q <= 1'b0;
            case (state_i)
                ST_INIT:
                begin
                    // Power-up steps paced by the timer
                    if (init_count_i == INIT_STEP_CKE)
                        cke_q <= 1'b1;
                    else if (init_count_i == INIT_STEP_PALL)
                    begin
                        cmd_q         <= CMD_PRECHARGE;
                        addr_q.col.ap <= 1'b1;
                    end
                    else if (init_count_i == INIT_STEP_REF1 || init_count_i == INIT_STEP_REF2)
                        cmd_q <= CMD_REFRESH;
                    else if (init_count_i == INIT_STEP_MODE)
                    begin
                        cmd_q       <= CMD_LOAD_MODE;
                        addr_q.mode <= MODE_CAS2;
                    end
                end
                ST_ACTIVATE:
                begin
                    cmd_q      <= CMD_ACTIVE;
                    addr_q.row <= ADDR_BUS_W'(row);
                    bank_q     <= bank;
                end
                ST_PRECHARGE:
                begin
                    // All banks before refresh, else only the missed bank
                    cmd_q         <= CMD_PRECHARGE;
                    addr_q.col.ap <= close_all_i;
                    bank_q        <= bank;
                end
                ST_REFRESH: cmd_q <= CMD_REFRESH;
                ST_READ:
                begin
                    cmd_q  <= CMD_READ;
                    addr_q <= col_word;
                    bank_q <= bank;
                    dqm_q  <= '0;
                end
                ST_WRITE:
                begin
                    cmd_q   <= CMD_WRITE;
                    addr_q  <= col_word;
                    bank_q  <= bank;
                    // DQM high masks the byte out
                    dqm_q   <= ~wr_i;
                    dq_oe_q <= 1'b1;
                end
                default: ;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Read markers and ack
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            rd_q  <= '0;
            ack_q <= 1'b0;
        end
        else
        begin
            rd_q  <= {rd_q[READ_LATENCY-1:0], state_i == ST_READ};
            ack_q <= (state_i == ST_WRITE) || rd_q[READ_LATENCY];
        end
    end

    // Write data, two-stage DQ sampler, read word held with its ack
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            data_q    <= '0;
            sample0_q <= '0;
            sample1_q <= '0;
            rdata_q   <= '0;
        end
        else
        begin
            if (state_i == ST_WRITE)
                data_q <= wdata_i;
            sample0_q <= dq_i;
            sample1_q <= sample0_q;
            if (rd_q[READ_LATENCY])
                rdata_q <= sample1_q;
        end
    end

    assign cke_o   = cke_q;
    assign cs_o    = cmd_q[3];
    assign ras_o   = cmd_q[2];
    assign cas_o   = cmd_q[1];
    assign we_o    = cmd_q[0];
    assign ba_o    = bank_q;
    assign addr_o  = addr_q;
    assign dqm_o   = dqm_q;
    assign dq_o    = data_q;
    assign dq_oe_o = dq_oe_q;
    assign ack_o   = ack_q;
    assign rdata_o = rdata_q;

endmodule

/* src/sdram_sequencer.sv */
// SDRAM main state machine
`timescale 1ns/1ns

module sdram_sequencer
#(
    parameter int READ_LATENCY = 2
)
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  req_rd_i,
    input  logic                  req_any_i,
    input  logic                  refresh_pending_i,
    input  logic                  bank_open_i,
    input  logic                  row_hit_i,
    output sdram_pkg::seq_state_t state_o,
    output logic                  refresh_done_o,
    output logic                  open_row_o,
    output logic                  close_bank_o,
    output logic                  close_all_o
);
    import sdram_pkg::*;

    seq_state_t         state_q;
    seq_state_t         next_state;
    seq_state_t         target_q;
    seq_state_t         target;
    seq_state_t         resume_q;
    logic [DELAY_W-1:0] delay_q;
    logic [DELAY_W-1:0] delay;
    logic               chain_rd;
    logic               chain_wr;
    seq_state_t         access;

    // Hit on the next request keeps the row busy without idling
    assign chain_rd = !refresh_pending_i && req_any_i && req_rd_i && row_hit_i;
    assign chain_wr = !refresh_pending_i && req_any_i && !req_rd_i && row_hit_i;
    assign access   = req_rd_i ? ST_READ : ST_WRITE;

    // ----------------------------------------------------------------------
    // Next state
    // ----------------------------------------------------------------------
    always_comb
    begin
        next_state = state_q;
        target     = target_q;
        case (state_q)
            ST_INIT:
            begin
                // First refresh tick ends power-up
                if (refresh_pending_i)
                    next_state = ST_IDLE;
            end
            ST_IDLE:
            begin
                // Refresh first, all banks closed before it
                if (refresh_pending_i)
                begin
                    next_state = ST_PRECHARGE;
                    target     = ST_REFRESH;
                end
                else if (req_any_i)
                begin
                    if (row_hit_i)
                        next_state = access;
                    else
                    begin
                        // Miss closes the bank, idle bank opens directly
                        next_state = bank_open_i ? ST_PRECHARGE : ST_ACTIVATE;
                        target     = access;
                    end
                end
            end
            ST_ACTIVATE:  next_state = target;
            ST_READ:      next_state = ST_READ_WAIT;
            ST_READ_WAIT: next_state = chain_rd ? ST_READ : ST_IDLE;
            ST_WRITE:     next_state = chain_wr ? ST_WRITE : ST_IDLE;
            ST_PRECHARGE: next_state = (target == ST_REFRESH) ? ST_REFRESH : ST_ACTIVATE;
            ST_REFRESH:   next_state = ST_IDLE;
            ST_DELAY:     next_state = resume_q;
            default:      next_state = ST_IDLE;
        endcase
    end

    // ----------------------------------------------------------------------
    // Wait loaded on entry, counted down in DELAY
    // ----------------------------------------------------------------------
    always_comb
    begin
        case (state_q)
            ST_ACTIVATE:  delay = TRCD_CYCLES;
            ST_READ_WAIT: delay = chain_rd ? '0 : DELAY_W'(READ_LATENCY);
            ST_PRECHARGE: delay = TRP_CYCLES;
            ST_REFRESH:   delay = TRFC_CYCLES;
            ST_DELAY:     delay = delay_q - DELAY_W'(1);
            default:      delay = '0;
        endcase
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            state_q  <= ST_INIT;
            target_q <= ST_IDLE;
            resume_q <= ST_IDLE;
            delay_q  <= '0;
        end
        else
        begin
            target_q <= target;
            delay_q  <= delay;
            // Remember where to go once the wait ends
            if (state_q != ST_DELAY && delay != '0)
                resume_q <= next_state;
            state_q <= (delay != '0) ? ST_DELAY : next_state;
        end
    end

    // Tracker updates follow the commands issued from these states
    assign open_row_o     = (state_q == ST_ACTIVATE);
    assign close_all_o    = (state_q == ST_PRECHARGE) && (target_q == ST_REFRESH);
    assign close_bank_o   = (state_q == ST_PRECHARGE) && (target_q != ST_REFRESH);
    assign refresh_done_o = (state_q == ST_REFRESH);
    assign state_o        = state_q;

endmodule

/* src/sdram_bank_tracker.sv */
// SDRAM open row table
`timescale 1ns/1ns

module sdram_bank_tracker
#(
    parameter int ROW_W = 13
)
(
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic [sdram_pkg::BANK_W-1:0] bank_i,
    input  logic [ROW_W-1:0]             row_i,
    input  logic                         open_row_i,
    input  logic                         close_bank_i,
    input  logic                         close_all_i,
    output logic                         bank_open_o,
    output logic                         row_hit_o
);
    import sdram_pkg::*;

    localparam int BANKS = 2 ** BANK_W;

    logic [BANKS-1:0] open_q;
    logic [ROW_W-1:0] row_q [BANKS];

    // One open flag per bank
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            open_q <= '0;
        else if (close_all_i)
            open_q <= '0;
        else if (close_bank_i)
            open_q[bank_i] <= 1'b0;
        else if (open_row_i)
            open_q[bank_i] <= 1'b1;
    end

    // Row address latched on activate
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            for (int b = 0; b < BANKS; b++)
                row_q[b] <= '0;
        end
        else if (open_row_i)
            row_q[bank_i] <= row_i;
    end

    assign bank_open_o = open_q[bank_i];
    assign row_hit_o   = open_q[bank_i] && (row_q[bank_i] == row_i);

endmodule

/* src/sdram_refresh_timer.sv */
// SDRAM power-up and refresh timer
`timescale 1ns/1ns

module sdram_refresh_timer
#(
    parameter int START_CYCLES   = 5100,
    parameter int REFRESH_CYCLES = 780
)
(
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          refresh_done_i,
    output logic                          refresh_pending_o,
    output logic [sdram_pkg::TIMER_W-1:0] init_count_o
);
    import sdram_pkg::*;

    logic [TIMER_W-1:0] count_q;
    logic               pending_q;

    // Power-up delay first, power-up steps fit in the extra margin
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            count_q <= TIMER_W'(START_CYCLES + 2 * int'(INIT_STEP_CKE));
        else if (count_q == '0)
            count_q <= TIMER_W'(REFRESH_CYCLES);
        else
            count_q <= count_q - TIMER_W'(1);
    end

    // Terminal count wins over a refresh in the same cycle
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            pending_q <= 1'b0;
        else if (count_q == '0)
            pending_q <= 1'b1;
        else if (refresh_done_i)
            pending_q <= 1'b0;
    end

    assign refresh_pending_o = pending_q;
    assign init_count_o      = count_q;

endmodule

/* src/sdram_pkg.sv */
// SDRAM controller shared definitions

package sdram_pkg;

    // ----------------------------------------------------------------------
    // Bus widths
    // ----------------------------------------------------------------------
    localparam int BANK_W     = 2;
    localparam int ADDR_BUS_W = 13;
    localparam int DATA_W     = 32;
    localparam int MASK_W     = 4;
    localparam int DELAY_W    = 4;
    localparam int TIMER_W    = 17;
    // Auto-precharge / all-banks flag on the address bus
    localparam int AP_BIT     = 10;

    // Command pins, cs ras cas we from msb
    typedef enum logic [3:0] {
        CMD_LOAD_MODE = 4'b0000,
        CMD_REFRESH   = 4'b0001,
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_WRITE     = 4'b0100,
        CMD_READ      = 4'b0101,
        CMD_NOP       = 4'b0111
    } sdram_cmd_t;

    // Main FSM states
    typedef enum logic [3:0] {
        ST_INIT, ST_DELAY, ST_IDLE, ST_ACTIVATE, ST_READ,
        ST_READ_WAIT, ST_WRITE, ST_PRECHARGE, ST_REFRESH
    } seq_state_t;

    // Column view of the address bus
    typedef struct packed {
        logic [ADDR_BUS_W-AP_BIT-2:0] rsvd;
        logic                         ap;
        logic [AP_BIT-1:0]            column;
    } sdram_col_t;

    // Mode register view
    typedef struct packed {
        logic [2:0] rsvd;
        logic       write_burst;
        logic [1:0] op_mode;
        logic [2:0] cas_latency;
        logic       burst_type;
        logic [2:0] burst_len;
    } sdram_mode_t;

    // One address bus word, three decodings
    typedef union packed {
        logic [ADDR_BUS_W-1:0] row;
        sdram_col_t            col;
        sdram_mode_t           mode;
    } sdram_addr_u;

    // ----------------------------------------------------------------------
    // Timing at 50 MHz
    // ----------------------------------------------------------------------
    localparam logic [DELAY_W-1:0] TRCD_CYCLES = 4'd1;
    localparam logic [DELAY_W-1:0] TRP_CYCLES  = 4'd1;
    localparam logic [DELAY_W-1:0] TRFC_CYCLES = 4'd3;

    // Burst length 1, sequential, CAS latency 2
    localparam sdram_mode_t MODE_CAS2 = '{rsvd: 3'b000, write_burst: 1'b0, op_mode: 2'b00,
                                          cas_latency: 3'd2, burst_type: 1'b0,
                                          burst_len: 3'b000};

    // Timer values for the power-up steps
    localparam logic [TIMER_W-1:0] INIT_STEP_CKE  = 17'd50;
    localparam logic [TIMER_W-1:0] INIT_STEP_PALL = 17'd40;
    localparam logic [TIMER_W-1:0] INIT_STEP_REF1 = 17'd30;
    localparam logic [TIMER_W-1:0] INIT_STEP_REF2 = 17'd20;
    localparam logic [TIMER_W-1:0] INIT_STEP_MODE = 17'd10;

endpackage
